// File: hw/bp_pkg.sv
package bp_pkg;

	localparam int ADDR_WIDTH = 64; // full instruction address.
	localparam int INDEX_WIDTH = 8; // low address bits pick the entry.
	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH; // the remaining high bits.
	localparam int TABLE_DEPTH = 1 << INDEX_WIDTH; // one entry per index value.
	localparam int STAT_WIDTH = 32; // wraps silently.

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [INDEX_WIDTH-1:0] index_t;
	typedef logic [TAG_WIDTH-1:0] tag_t;
	typedef logic [STAT_WIDTH-1:0] stat_t;

	// bit 1 of the encoding gives the predicted direction.
	typedef enum logic [1:0] {
		STRONG_NOT_TAKEN = 2'b00,
		WEAK_NOT_TAKEN = 2'b01,
		WEAK_TAKEN = 2'b10,
		STRONG_TAKEN = 2'b11
	} counter_e;

	// one table slot as seen by the update stage.
	typedef struct packed {
		logic valid;
		tag_t tag;
		counter_e counter;
	} table_entry_t;

	// single write port into the table.
	typedef struct packed {
		logic enable;
		index_t index;
		table_entry_t entry;
	} table_write_t;

endpackage

// File: hw/predictor_table.sv
`timescale 1ns/100ps

module predictor_table import bp_pkg::*; (
	input logic clk,
	input logic reset,
	input index_t lookup_index,
	input tag_t lookup_tag,
	input index_t recent_index,
	input table_write_t table_write,
	output logic prediction,
	output table_entry_t recent_entry
);

	tag_t tag_mem [TABLE_DEPTH]; // stored tags.
	counter_e counter_mem [TABLE_DEPTH]; // 2-bit saturating counters.
	logic [TABLE_DEPTH-1:0] valid_bits; // one bit per entry.

	tag_t lookup_stored_tag;
	counter_e lookup_counter;
	logic lookup_valid;
	logic lookup_hit;

	// lookup port, purely combinational from the stored state.
	// a write landing on the same edge is not visible yet.
	assign lookup_stored_tag = tag_mem[lookup_index];
	assign lookup_counter = counter_mem[lookup_index];
	assign lookup_valid = valid_bits[lookup_index];

	assign lookup_hit = lookup_valid && (lookup_stored_tag == lookup_tag);

	// taken only on a valid hit in a taken state.
	assign prediction = lookup_hit && lookup_counter[1];

	// update read port returns the raw entry.
	assign recent_entry.valid = valid_bits[recent_index];
	assign recent_entry.tag = tag_mem[recent_index];
	assign recent_entry.counter = counter_mem[recent_index];

	// valid vector is the only state cleared by reset.
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0; // every entry misses after this.
		end else if (table_write.enable) begin
			valid_bits[table_write.index] <= table_write.entry.valid;
		end
	end

	// tag and counter storage.
	always_ff @(posedge clk) begin
		if (table_write.enable) begin
			tag_mem[table_write.index] <= table_write.entry.tag;
			counter_mem[table_write.index] <= table_write.entry.counter;
		end
	end

endmodule

// File: hw/update_stage.sv
`timescale 1ns/100ps

module update_stage import bp_pkg::*; (
	input logic clk,
	input logic reset,
	input logic valid,
	input addr_t ip,
	input logic taken,
	input logic prediction,
	input table_entry_t recent_entry,
	output index_t recent_index,
	output table_write_t table_write,
	output logic resolve,
	output logic mispredict
);

	logic recent_valid; // a lookup waits for its outcome.
	addr_t recent_ip; // address of the last lookup.
	logic recent_prediction; // direction predicted for it.

	tag_t recent_tag;
	logic recent_hit;
	counter_e trained_counter;
	counter_e alloc_counter;
	table_entry_t new_entry;

	// one step toward the outcome, held at both ends.
	function automatic counter_e step_counter(input counter_e current, input logic dir);
		counter_e next;
		next = current;
		if (dir) begin
			case (current)
				STRONG_NOT_TAKEN: next = WEAK_NOT_TAKEN;
				WEAK_NOT_TAKEN: next = WEAK_TAKEN;
				WEAK_TAKEN: next = STRONG_TAKEN;
				default: next = STRONG_TAKEN; // saturated.
			endcase
		end else begin
			case (current)
				STRONG_TAKEN: next = WEAK_TAKEN;
				WEAK_TAKEN: next = WEAK_NOT_TAKEN;
				WEAK_NOT_TAKEN: next = STRONG_NOT_TAKEN;
				default: next = STRONG_NOT_TAKEN; // saturated.
			endcase
		end
		return next;
	endfunction

	// control bit of the recent register.
	always_ff @(posedge clk) begin
		if (reset) begin
			recent_valid <= 1'b0;
		end else begin
			recent_valid <= valid;
		end
	end

	// payload of the recent register.
	always_ff @(posedge clk) begin
		recent_ip <= ip;
		recent_prediction <= prediction;
	end

	assign recent_index = recent_ip[INDEX_WIDTH-1:0];
	assign recent_tag = recent_ip[ADDR_WIDTH-1:INDEX_WIDTH];

	// hit needs both the valid bit and a matching tag.
	assign recent_hit = recent_entry.valid && (recent_entry.tag == recent_tag);

	assign trained_counter = step_counter(recent_entry.counter, taken);
	assign alloc_counter = taken ? WEAK_TAKEN : WEAK_NOT_TAKEN; // fresh entries start weak.

	always_comb begin
		new_entry.valid = 1'b1;
		new_entry.tag = recent_tag; // same tag on a hit anyway.
		if (recent_hit) begin
			new_entry.counter = trained_counter;
		end else begin
			new_entry.counter = alloc_counter; // reallocate on a miss.
		end
	end

	// table applies this at the coming edge.
	assign table_write.enable = recent_valid;
	assign table_write.index = recent_index;
	assign table_write.entry = new_entry;

	assign resolve = recent_valid;
	assign mispredict = recent_valid && (recent_prediction != taken);

endmodule

// File: hw/prediction_stats.sv
`timescale 1ns/100ps

module prediction_stats import bp_pkg::*; (
	input logic clk,
	input logic reset,
	input logic resolve,
	input logic mispredict,
	output stat_t lookup_count,
	output stat_t mispredict_count
);

	logic count_mispredict;

	// a mispredict only counts alongside a resolve.
	assign count_mispredict = resolve && mispredict;

	// resolved lookups, wraps at the top.
	always_ff @(posedge clk) begin
		if (reset) begin
			lookup_count <= '0;
		end else if (resolve) begin
			lookup_count <= lookup_count + 1'b1;
		end
	end

	// wrong predictions among them.
	always_ff @(posedge clk) begin
		if (reset) begin
			mispredict_count <= '0;
		end else if (count_mispredict) begin
			mispredict_count <= mispredict_count + 1'b1;
		end
	end

endmodule

// File: hw/branch_predictor_top.sv
`timescale 1ns/100ps

module branch_predictor_top import bp_pkg::*; (
	input logic clk,
	input logic reset,
	input logic valid,
	input addr_t ip,
	input logic taken,
	output logic prediction,
	output stat_t lookup_count,
	output stat_t mispredict_count
);

	index_t lookup_index;
	tag_t lookup_tag;
	index_t recent_index;
	table_entry_t recent_entry;
	table_write_t table_write;
	logic resolve;
	logic mispredict;

	// low bits index the table, high bits form the tag.
	assign lookup_index = ip[INDEX_WIDTH-1:0];
	assign lookup_tag = ip[ADDR_WIDTH-1:INDEX_WIDTH];

	predictor_table u_table (
		.clk(clk),
		.reset(reset),
		.lookup_index(lookup_index),
		.lookup_tag(lookup_tag),
		.recent_index(recent_index),
		.table_write(table_write),
		.prediction(prediction),
		.recent_entry(recent_entry)
	);

	update_stage u_update (
		.clk(clk),
		.reset(reset),
		.valid(valid),
		.ip(ip),
		.taken(taken),
		.prediction(prediction), // direction given to the fetch unit.
		.recent_entry(recent_entry),
		.recent_index(recent_index),
		.table_write(table_write),
		.resolve(resolve),
		.mispredict(mispredict)
	);

	prediction_stats u_stats (
		.clk(clk),
		.reset(reset),
		.resolve(resolve),
		.mispredict(mispredict),
		.lookup_count(lookup_count),
		.mispredict_count(mispredict_count)
	);

endmodule

// File: verification/branch_predictor_asserts.sv
`timescale 1ns/100ps

module branch_predictor_asserts import bp_pkg::*; (
	input logic clk,
	input logic reset,
	input table_write_t table_write,
	input table_entry_t recent_entry,
	input logic resolve
);

	logic entry_hit;
	logic [2:0] old_count; // widened so a step never wraps.
	logic [2:0] new_count;
	logic one_step;
	int failure_count = 0; // failed assertions so far.

	// the written tag is always the recent lookup's tag.
	assign entry_hit = recent_entry.valid && (recent_entry.tag == table_write.entry.tag);
	assign old_count = {1'b0, recent_entry.counter};
	assign new_count = {1'b0, table_write.entry.counter};
	assign one_step = (new_count == old_count) || (new_count == old_count + 3'd1) ||
		(old_count == new_count + 3'd1);

	miss_allocates_weak: assert property (@(posedge clk) disable iff (reset)
		table_write.enable && !entry_hit |->
			table_write.entry.valid &&
			(table_write.entry.counter == WEAK_NOT_TAKEN ||
			table_write.entry.counter == WEAK_TAKEN))
		else begin
			$error("table write on a miss is not a valid weak entry");
			failure_count++;
		end

	hit_moves_one_step: assert property (@(posedge clk) disable iff (reset)
		table_write.enable && entry_hit |-> table_write.entry.valid && one_step)
		else begin
			$error("table write on a hit moved the counter by more than one step");
			failure_count++;
		end

	no_resolve_after_reset: assert property (@(posedge clk) reset |=> !resolve)
		else begin
			$error("resolve was high in the cycle after reset");
			failure_count++;
		end

endmodule

bind update_stage branch_predictor_asserts u_asserts (
	.clk(clk),
	.reset(reset),
	.table_write(table_write),
	.recent_entry(recent_entry),
	.resolve(resolve)
);

// File: verification/branch_predictor_tb.sv
`timescale 1ns/100ps

module branch_predictor_tb import bp_pkg::*; ();

	// one lookup as the model keeps it until its outcome is written.
	typedef struct packed {
		logic valid;
		addr_t ip;
		logic outcome;
		logic predicted;
	} lookup_rec_t;

	logic clk;
	logic reset;
	logic valid;
	addr_t ip;
	logic taken;
	logic prediction;
	stat_t lookup_count;
	stat_t mispredict_count;

	bit model_valid [TABLE_DEPTH];
	tag_t model_tag [TABLE_DEPTH];
	logic [1:0] model_counter [TABLE_DEPTH]; // 0 strong not-taken up to 3 strong taken.
	stat_t exp_lookup_count;
	stat_t exp_mispredict_count;
	logic exp_prediction;

	lookup_rec_t awaiting_outcome; // presented last cycle, outcome goes out next.
	lookup_rec_t awaiting_write; // outcome driven, table write at the coming edge.
	bit check_en;
	int error_count;
	logic [31:0] rng_state;
	tag_t tag_pool [4];
	index_t index_pool [4];

	branch_predictor_top dut (
		.clk(clk),
		.reset(reset),
		.valid(valid),
		.ip(ip),
		.taken(taken),
		.prediction(prediction),
		.lookup_count(lookup_count),
		.mispredict_count(mispredict_count)
	);

	always #50 clk = ~clk; // 100 ns period.

	task automatic report_failure(input string what);
		error_count++;
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "stopping at the first error");
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// small pools so that hits and conflicts are frequent.
	function automatic addr_t random_address();
		logic [31:0] r;
		r = next_random();
		return {tag_pool[r[1:0]], index_pool[r[3:2]]};
	endfunction

	// expected direction for an address from the model table.
	function automatic logic model_prediction(input addr_t a);
		index_t idx;
		tag_t t;
		idx = a[INDEX_WIDTH-1:0];
		t = a[ADDR_WIDTH-1:INDEX_WIDTH];
		return model_valid[idx] && (model_tag[idx] == t) && (model_counter[idx] >= 2'd2);
	endfunction

	function automatic logic [1:0] trained(input logic [1:0] c, input logic outcome);
		if (outcome && c != 2'd3) begin
			return c + 2'd1;
		end
		if (!outcome && c != 2'd0) begin
			return c - 2'd1;
		end
		return c; // held at the end.
	endfunction

	task automatic apply_outcome(input lookup_rec_t rec);
		index_t idx;
		tag_t t;
		idx = rec.ip[INDEX_WIDTH-1:0];
		t = rec.ip[ADDR_WIDTH-1:INDEX_WIDTH];
		exp_lookup_count++;
		if (rec.predicted != rec.outcome) begin
			exp_mispredict_count++;
		end
		if (model_valid[idx] && model_tag[idx] == t) begin
			model_counter[idx] = trained(model_counter[idx], rec.outcome);
		end else begin
			model_valid[idx] = 1'b1; // reallocate with the new tag.
			model_tag[idx] = t;
			model_counter[idx] = rec.outcome ? 2'd2 : 2'd1;
		end
	endtask

	// one cycle: new lookup plus the outcome of the previous one.
	task automatic step(input logic v, input addr_t a, input logic outcome);
		lookup_rec_t rec;
		logic [31:0] noise;
		noise = next_random();
		@(negedge clk);
		if (awaiting_write.valid) begin
			apply_outcome(awaiting_write); // written at the edge just passed.
		end
		awaiting_write = awaiting_outcome;
		taken = awaiting_outcome.valid ? awaiting_outcome.outcome : noise[0]; // ignored if idle.
		valid = v;
		ip = a;
		exp_prediction = model_prediction(a);
		rec.valid = v;
		rec.ip = a;
		rec.outcome = outcome;
		rec.predicted = exp_prediction;
		awaiting_outcome = rec;
		check_en = 1'b1;
	endtask

	task automatic idle();
		step(1'b0, random_address(), 1'b0);
	endtask

	task automatic expect_direction(input logic want);
		assert (exp_prediction === want) else
			report_failure($sformatf("Error: prediction for ip %h expected %h, model gives %h",
				ip, want, exp_prediction));
	endtask

	// lookup, check its direction, then let the write land.
	task automatic train(input addr_t a, input logic outcome, input logic want);
		step(1'b1, a, outcome);
		expect_direction(want);
		idle();
	endtask

	task automatic wait_counts_clear();
		int n;
		n = 0;
		while ((lookup_count !== '0 || mispredict_count !== '0) && n < 20) begin
			@(negedge clk);
			n++;
		end
		assert (n < 20) else
			report_failure("timeout waiting for the statistics counters to clear after reset");
	endtask

	task automatic wait_for_drain();
		int n;
		n = 0;
		while ((awaiting_outcome.valid || awaiting_write.valid) && n < 10) begin
			idle();
			n++;
		end
		assert (n < 10) else
			report_failure("timeout waiting for the last outcomes to be counted");
	endtask

	// compare a quarter period before the rising edge.
	always @(negedge clk) begin
		#25;
		assert (dut.u_update.u_asserts.failure_count == 0) else
			report_failure("a bound assertion on the update stage failed");
		if (check_en) begin
			assert (prediction === exp_prediction) else
				report_failure($sformatf("Error: prediction for ip %h expected %h got %h",
					ip, exp_prediction, prediction));
			assert (lookup_count === exp_lookup_count) else
				report_failure($sformatf("Error: lookup_count expected %h got %h",
					exp_lookup_count, lookup_count));
			assert (mispredict_count === exp_mispredict_count) else
				report_failure($sformatf("Error: mispredict_count expected %h got %h",
					exp_mispredict_count, mispredict_count));
		end
	end

	initial begin
		addr_t addr_a;
		addr_t addr_b;
		stat_t held_lookups;
		stat_t held_mispredicts;
		logic [31:0] r;
		clk = 1'b0;
		reset = 1'b1;
		valid = 1'b0;
		ip = '0;
		taken = 1'b0;
		check_en = 1'b0;
		error_count = 0;
		rng_state = 32'h9829_59ae;
		exp_lookup_count = '0;
		exp_mispredict_count = '0;
		exp_prediction = 1'b0;
		awaiting_outcome = '0;
		awaiting_write = '0;
		tag_pool[0] = 56'h00_0000_0010_0000;
		tag_pool[1] = 56'h00_0000_0010_0001;
		tag_pool[2] = 56'h00_0000_0020_0000;
		tag_pool[3] = 56'hff_ffff_ffff_ff00;
		index_pool[0] = 8'h04;
		index_pool[1] = 8'h05;
		index_pool[2] = 8'h84;
		index_pool[3] = 8'hfc;
		for (int i = 0; i < TABLE_DEPTH; i++) begin
			model_valid[i] = 1'b0;
		end
		repeat (10) @(negedge clk);
		reset = 1'b0;
		wait_counts_clear();

		// empty table predicts not-taken everywhere.
		for (int i = 0; i < 8; i++) begin
			step(1'b1, {tag_pool[3], index_t'(16 * i + 1)}, i[0]);
			expect_direction(1'b0);
		end

		// allocation, then saturation in both directions.
		addr_a = {tag_pool[1], index_pool[0]};
		addr_b = {tag_pool[2], index_pool[0]};
		train(addr_a, 1'b1, 1'b0);
		train(addr_a, 1'b1, 1'b1);
		train(addr_a, 1'b0, 1'b1);
		train(addr_a, 1'b0, 1'b1);
		train(addr_a, 1'b1, 1'b0);
		train(addr_a, 1'b0, 1'b1);
		train(addr_a, 1'b0, 1'b0);

		// back to back, the second lookup sees the entry before the first write.
		step(1'b1, addr_a, 1'b1);
		expect_direction(1'b0);
		step(1'b1, addr_a, 1'b1);
		expect_direction(1'b0);
		idle();
		train(addr_a, 1'b0, 1'b1);

		// same index, different tags.
		train(addr_b, 1'b1, 1'b0);
		train(addr_a, 1'b1, 1'b0);
		train(addr_b, 1'b0, 1'b0);
		train(addr_b, 1'b1, 1'b0);
		train(addr_b, 1'b0, 1'b1);

		// idle cycles touch neither table nor counts.
		idle();
		held_lookups = lookup_count;
		held_mispredicts = mispredict_count;
		for (int i = 0; i < 6; i++) begin
			step(1'b0, addr_b, i[0]);
		end
		assert (lookup_count === held_lookups) else
			report_failure($sformatf("Error: lookup_count expected %h got %h",
				held_lookups, lookup_count));
		assert (mispredict_count === held_mispredicts) else
			report_failure($sformatf("Error: mispredict_count expected %h got %h",
				held_mispredicts, mispredict_count));
		train(addr_b, 1'b0, 1'b0);

		// long random run, about three lookups in four cycles.
		for (int i = 0; i < 3000; i++) begin
			r = next_random();
			step(r[5:4] != 2'b00, random_address(), r[8]);
		end

		wait_for_drain();
		@(posedge clk);
		$display("resolved %0d lookups, %0d mispredicted", lookup_count, mispredict_count);
		if (error_count == 0 && dut.u_update.u_asserts.failure_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: sources.f
hw/bp_pkg.sv
hw/predictor_table.sv
hw/update_stage.sv
hw/prediction_stats.sv
hw/branch_predictor_top.sv
verification/branch_predictor_asserts.sv
verification/branch_predictor_tb.sv
